//--- cpu_types_pkg.sv
// ========================================
// byte addresses, only word-aligned ones are used
// latency counts extra wait cycles, 0 to 15
// ========================================

package cpu_types_pkg;

  // data word as seen by caches and RAM
  typedef logic [31:0] word_t;

  // byte address, low two bits always zero
  typedef logic [31:0] addr_t;

  // extra RAM wait cycles before an access completes
  typedef logic [3:0] latency_t;

  // RAM handshake state
  // FREE   no request on the RAM port
  // BUSY   request present, latency still counting
  // ACCESS one cycle, read word valid or write taken
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS
  } ramstate_t;

endpackage

//--- coherence_pkg.sv
// ========================================
// exactly two cores, so a core index is one bit
// ========================================

package coherence_pkg;

  // which of the two cores
  typedef logic core_t;

  // controller states
  // STORE_*  two-word write-back
  // CACHE_*  forward from the snooped cache plus write-back to RAM
  // LOAD_*   two-word load from RAM after a clean snoop
  typedef enum logic [3:0]
  {
    IDLE,
    INSTRUCTION,
    STORE_1,
    STORE_2,
    ARBITRATE,
    SNOOP,
    CACHE_1,
    CACHE_2,
    LOAD_1,
    LOAD_2
  } cc_state_t;

endpackage

//--- ram_latency_cfg.sv
// ========================================
// a write while the RAM port is active is dropped, not held
// ========================================

`timescale 1ns/10ps

module ram_latency_cfg (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     cfg_wen,
  input  cpu_types_pkg::latency_t  cfg_latency,
  // no read or write on the RAM port
  input  logic                     ram_idle,
  output cpu_types_pkg::latency_t  latency
);

  // latency comes up as zero extra cycles
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      latency <= '0;
    end
    else if (cfg_wen && ram_idle)
    begin
      // only between accesses, a running count keeps its value
      latency <= cfg_latency;
    end
  end

endmodule

//--- ram_model.sv
// ========================================
// contents clear at reset; address bits above MEM_ADDR_BITS+1 are ignored
// ========================================

`timescale 1ns/10ps

module ram_model #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      ramREN,
  input  logic                      ramWEN,
  input  cpu_types_pkg::addr_t      ramaddr,
  input  cpu_types_pkg::word_t      ramstore,
  input  cpu_types_pkg::latency_t   latency,
  output cpu_types_pkg::word_t      ramload,
  output cpu_types_pkg::ramstate_t  ramstate
);

  localparam int WORDS = 2 ** MEM_ADDR_BITS;

  cpu_types_pkg::word_t     mem [WORDS];
  cpu_types_pkg::latency_t  count;
  cpu_types_pkg::addr_t     last_addr;
  logic                     last_wen;
  // a request is being counted
  logic                     armed;
  logic                     req;
  // same request as last cycle
  logic                     same;
  logic [MEM_ADDR_BITS-1:0] widx;

  assign req  = ramREN | ramWEN;
  assign widx = ramaddr[MEM_ADDR_BITS+1:2];
  assign same = armed && (ramaddr == last_addr) && (ramWEN == last_wen);

  always_comb
  begin
    if (!req)
    begin
      ramstate = cpu_types_pkg::FREE;
    end
    else if (same && (count == '0))
    begin
      ramstate = cpu_types_pkg::ACCESS;
    end
    else
    begin
      ramstate = cpu_types_pkg::BUSY;
    end
  end

  // reload on a new request or address, and again after each access
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      armed <= 1'b0;
      count <= '0;
    end
    else if (!req)
    begin
      armed <= 1'b0;
    end
    else if (!same || (ramstate == cpu_types_pkg::ACCESS))
    begin
      armed <= 1'b1;
      count <= latency;
    end
    else
    begin
      count <= count - 1'b1;
    end
  end

  // previous request, compared while armed
  always_ff @(posedge CLK)
  begin
    last_addr <= ramaddr;
    last_wen  <= ramWEN;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < WORDS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (ramWEN && (ramstate == cpu_types_pkg::ACCESS))
    begin
      mem[widx] <= ramstore;
    end
  end

  // read path, valid in the ACCESS cycle
  assign ramload = mem[widx];

endmodule

//--- coherence_control.sv
// ========================================
// two cores, one operation outstanding; caches hold requests until their wait drops
// an upgrade is a single ccinv cycle in ARBITRATE, the writer drops ccwrite after it
// ========================================

`timescale 1ns/10ps

module coherence_control (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      iREN        [2],
  input  logic                      dREN        [2],
  input  logic                      dWEN        [2],
  input  logic                      ccwrite     [2],
  input  logic                      cctrans     [2],
  input  cpu_types_pkg::addr_t      iaddr       [2],
  input  cpu_types_pkg::addr_t      daddr       [2],
  input  cpu_types_pkg::word_t      dstore      [2],
  input  cpu_types_pkg::ramstate_t  ramstate,
  input  cpu_types_pkg::word_t      ramload,
  output logic                      iwait       [2],
  output logic                      dwait       [2],
  output logic                      ccwait      [2],
  output logic                      ccinv       [2],
  output cpu_types_pkg::word_t      iload       [2],
  output cpu_types_pkg::word_t      dload       [2],
  output cpu_types_pkg::addr_t      ccsnoopaddr [2],
  output cpu_types_pkg::addr_t      ramaddr,
  output cpu_types_pkg::word_t      ramstore,
  output logic                      ramREN,
  output logic                      ramWEN
);

  coherence_pkg::cc_state_t state;
  coherence_pkg::cc_state_t next_state;
  // least recently served core, wins a tie
  coherence_pkg::core_t     lru;
  coherence_pkg::core_t     next_lru;
  // core owning the current operation
  coherence_pkg::core_t     requester;
  coherence_pkg::core_t     next_requester;
  // the other core, target of snoops
  coherence_pkg::core_t     snooped;
  // core chosen among readers / upgrading writers in ARBITRATE
  coherence_pkg::core_t     reader;
  coherence_pkg::core_t     writer;
  logic                     ram_done;

  // tie break: the lru core if it asks, otherwise the other one
  function automatic coherence_pkg::core_t pick_core(
    input logic                 lru_req,
    input coherence_pkg::core_t lru_core
  );
    return lru_req ? lru_core : ~lru_core;
  endfunction

  assign ram_done = (ramstate == cpu_types_pkg::ACCESS);
  assign snooped  = ~requester;
  assign reader   = pick_core(dREN[lru], lru);
  assign writer   = pick_core(ccwrite[lru], lru);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= coherence_pkg::IDLE;
      lru       <= 1'b0;
      requester <= 1'b0;
    end
    else
    begin
      state     <= next_state;
      lru       <= next_lru;
      requester <= next_requester;
    end
  end

  // next state, owner and lru
  always_comb
  begin
    next_state     = state;
    next_requester = requester;
    next_lru       = lru;

    case (state)
      coherence_pkg::IDLE:
      begin
        // write-backs first, then loads and upgrades, then fetches
        if (dWEN[0] || dWEN[1])
        begin
          next_state     = coherence_pkg::STORE_1;
          next_requester = pick_core(dWEN[lru], lru);
        end
        else if (dREN[0] || dREN[1] || ccwrite[0] || ccwrite[1])
        begin
          next_state = coherence_pkg::ARBITRATE;
        end
        else if (iREN[0] || iREN[1])
        begin
          next_state     = coherence_pkg::INSTRUCTION;
          next_requester = pick_core(iREN[lru], lru);
        end
      end

      coherence_pkg::INSTRUCTION:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::IDLE;
          next_lru   = ~requester;
        end
      end

      coherence_pkg::STORE_1:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::STORE_2;
        end
      end

      coherence_pkg::STORE_2:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::IDLE;
          next_lru   = ~requester;
        end
      end

      coherence_pkg::ARBITRATE:
      begin
        if (dREN[0] || dREN[1])
        begin
          next_state     = coherence_pkg::SNOOP;
          next_requester = reader;
        end
        else
        begin
          // upgrade only, done in this cycle
          next_state = coherence_pkg::IDLE;
          if (ccwrite[0] || ccwrite[1])
          begin
            next_lru = ~writer;
          end
        end
      end

      coherence_pkg::SNOOP:
      begin
        // modified copy in the other cache wins over RAM
        if (cctrans[snooped])
        begin
          next_state = coherence_pkg::CACHE_1;
        end
        else
        begin
          next_state = coherence_pkg::LOAD_1;
        end
      end

      coherence_pkg::CACHE_1:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::CACHE_2;
        end
      end

      coherence_pkg::LOAD_1:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::LOAD_2;
        end
      end

      coherence_pkg::CACHE_2,
      coherence_pkg::LOAD_2:
      begin
        if (ram_done)
        begin
          next_state = coherence_pkg::IDLE;
          next_lru   = ~requester;
        end
      end

      default:
      begin
        next_state = coherence_pkg::IDLE;
      end
    endcase
  end

  // cache and RAM side outputs
  always_comb
  begin
    iwait       = '{default: 1'b1};
    dwait       = '{default: 1'b1};
    ccwait      = '{default: 1'b0};
    ccinv       = '{default: 1'b0};
    iload       = '{default: '0};
    dload       = '{default: '0};
    ccsnoopaddr = '{default: '0};
    ramaddr     = '0;
    ramstore    = '0;
    ramREN      = 1'b0;
    ramWEN      = 1'b0;

    case (state)
      coherence_pkg::INSTRUCTION:
      begin
        ramREN           = 1'b1;
        ramaddr          = iaddr[requester];
        iload[requester] = ramload;
        iwait[requester] = !ram_done;
      end

      coherence_pkg::STORE_1,
      coherence_pkg::STORE_2:
      begin
        // cache moves to its second word after the first dwait low
        ramWEN           = 1'b1;
        ramaddr          = daddr[requester];
        ramstore         = dstore[requester];
        dwait[requester] = !ram_done;
      end

      coherence_pkg::ARBITRATE:
      begin
        if (dREN[0] || dREN[1])
        begin
          // hold the other cache ahead of the snoop
          ccwait[~reader]      = 1'b1;
          ccsnoopaddr[~reader] = daddr[reader];
        end
        else if (ccwrite[0] || ccwrite[1])
        begin
          // write hit on shared, drop the other copy
          ccinv[~writer]       = 1'b1;
          ccsnoopaddr[~writer] = daddr[writer];
        end
      end

      coherence_pkg::SNOOP:
      begin
        ccwait[snooped]      = 1'b1;
        ccsnoopaddr[snooped] = daddr[requester];
      end

      coherence_pkg::CACHE_1,
      coherence_pkg::CACHE_2:
      begin
        ccwait[snooped]      = 1'b1;
        ccsnoopaddr[snooped] = daddr[requester];
        // requester wants to write, so the owner gives up the block
        ccinv[snooped]       = ccwrite[requester];
        dload[requester]     = dstore[snooped];
        // both words go to the requester's address
        ramWEN               = 1'b1;
        ramaddr              = daddr[requester];
        ramstore             = dstore[snooped];
        dwait[requester]     = !ram_done;
        dwait[snooped]       = !ram_done;
      end

      coherence_pkg::LOAD_1,
      coherence_pkg::LOAD_2:
      begin
        ccwait[snooped]      = 1'b1;
        ccsnoopaddr[snooped] = daddr[requester];
        ramREN               = 1'b1;
        ramaddr              = daddr[requester];
        dload[requester]     = ramload;
        dwait[requester]     = !ram_done;
      end

      default:
      begin
        // idle, defaults hold
      end
    endcase
  end

endmodule

//--- memory_subsystem.sv
// ========================================
// two caches on one word-wide RAM; latency loads only while the RAM port is idle
// ========================================

`timescale 1ns/10ps

module memory_subsystem #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     cfg_wen,
  input  cpu_types_pkg::latency_t  cfg_latency,
  input  logic                     iREN        [2],
  input  logic                     dREN        [2],
  input  logic                     dWEN        [2],
  input  logic                     ccwrite     [2],
  input  logic                     cctrans     [2],
  input  cpu_types_pkg::addr_t     iaddr       [2],
  input  cpu_types_pkg::addr_t     daddr       [2],
  input  cpu_types_pkg::word_t     dstore      [2],
  output logic                     iwait       [2],
  output logic                     dwait       [2],
  output logic                     ccwait      [2],
  output logic                     ccinv       [2],
  output cpu_types_pkg::word_t     iload       [2],
  output cpu_types_pkg::word_t     dload       [2],
  output cpu_types_pkg::addr_t     ccsnoopaddr [2]
);

  // controller to RAM
  logic                      ramREN;
  logic                      ramWEN;
  cpu_types_pkg::addr_t      ramaddr;
  cpu_types_pkg::word_t      ramstore;
  cpu_types_pkg::word_t      ramload;
  cpu_types_pkg::ramstate_t  ramstate;
  cpu_types_pkg::latency_t   latency;

  coherence_control ctrl0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .iREN        (iREN),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .ccwrite     (ccwrite),
    .cctrans     (cctrans),
    .iaddr       (iaddr),
    .daddr       (daddr),
    .dstore      (dstore),
    .ramstate    (ramstate),
    .ramload     (ramload),
    .iwait       (iwait),
    .dwait       (dwait),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .iload       (iload),
    .dload       (dload),
    .ccsnoopaddr (ccsnoopaddr),
    .ramaddr     (ramaddr),
    .ramstore    (ramstore),
    .ramREN      (ramREN),
    .ramWEN      (ramWEN)
  );

  ram_model #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) ram0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .latency  (latency),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

  // idle means neither read nor write toward RAM
  ram_latency_cfg cfg0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .cfg_wen     (cfg_wen),
    .cfg_latency (cfg_latency),
    .ram_idle    (!ramREN && !ramWEN),
    .latency     (latency)
  );

endmodule

//--- memory_subsystem_checker.sv
// ========================================
// two cores only; fail_count holds the number of failed assertions
// ========================================

`timescale 1ns/10ps

module memory_subsystem_checker (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  iREN        [2],
  input logic                  dREN        [2],
  input logic                  dWEN        [2],
  input logic                  ccwrite     [2],
  input cpu_types_pkg::addr_t  daddr       [2],
  input logic                  ccwait      [2],
  input logic                  ccinv       [2],
  input cpu_types_pkg::addr_t  ccsnoopaddr [2],
  input logic                  ramREN,
  input logic                  ramWEN
);

  int   fail_count = 0;
  logic any_req;
  // set by the first request after reset
  logic seen_req;

  assign any_req = iREN[0] || iREN[1] || dREN[0] || dREN[1] ||
                   dWEN[0] || dWEN[1] || ccwrite[0] || ccwrite[1];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      seen_req <= 1'b0;
    end
    else if (any_req)
    begin
      seen_req <= 1'b1;
    end
  end

  // one RAM operation at a time
  single_ram_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramREN && ramWEN))
    else
    begin
      fail_count++;
      $error("ramREN and ramWEN high together");
    end

  // only one cache is ever held for a snoop
  single_ccwait: assert property (@(posedge CLK) disable iff (!nRST)
    !(ccwait[0] && ccwait[1]))
    else
    begin
      fail_count++;
      $error("ccwait high on both cores");
    end

  // invalidate names the other core's block
  inv_addr_0: assert property (@(posedge CLK) disable iff (!nRST)
    ccinv[0] |-> (ccsnoopaddr[0] != '0) && (ccsnoopaddr[0] == daddr[1]))
    else
    begin
      fail_count++;
      $error("ccinv to core 0 without matching ccsnoopaddr");
    end

  inv_addr_1: assert property (@(posedge CLK) disable iff (!nRST)
    ccinv[1] |-> (ccsnoopaddr[1] != '0) && (ccsnoopaddr[1] == daddr[0]))
    else
    begin
      fail_count++;
      $error("ccinv to core 1 without matching ccsnoopaddr");
    end

  // quiet out of reset until some cache asks
  quiet_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
    !seen_req |-> !ramREN && !ramWEN && !ccwait[0] && !ccwait[1])
    else
    begin
      fail_count++;
      $error("controller active before any request");
    end

endmodule

//--- tb_memory_subsystem.sv
// ========================================
// plays both caches; blocks are two words at 8-byte aligned bases
// ========================================

`timescale 1ns/10ps

module tb_memory_subsystem;

  localparam int MEM_ADDR_BITS = 10;
  localparam int MEM_WORDS     = 2 ** MEM_ADDR_BITS;
  localparam int CLK_PERIOD    = 20;
  localparam int NUM_TRANS     = 300;
  // two accesses of at most 16 cycles plus handshake overhead
  localparam int TRANS_CYCLES  = 2 * (16 + 4);
  // a transaction may evict first, so up to four accesses
  localparam int WATCHDOG_NS   = (NUM_TRANS * 2 * TRANS_CYCLES + 500) * CLK_PERIOD;
  localparam cpu_types_pkg::addr_t ADDR_BASE = 32'h0000_0100;

  logic                     CLK;
  logic                     nRST;
  logic                     cfg_wen;
  cpu_types_pkg::latency_t  cfg_latency;
  logic                     iREN        [2];
  logic                     dREN        [2];
  logic                     dWEN        [2];
  logic                     ccwrite     [2];
  logic                     cctrans     [2];
  cpu_types_pkg::addr_t     iaddr       [2];
  cpu_types_pkg::addr_t     daddr       [2];
  cpu_types_pkg::word_t     dstore      [2];
  logic                     iwait       [2];
  logic                     dwait       [2];
  logic                     ccwait      [2];
  logic                     ccinv       [2];
  cpu_types_pkg::word_t     iload       [2];
  cpu_types_pkg::word_t     dload       [2];
  cpu_types_pkg::addr_t     ccsnoopaddr [2];

  // reference memory and the modified block each cache holds
  cpu_types_pkg::word_t     model_mem [MEM_WORDS];
  logic                     mod_valid [2];
  cpu_types_pkg::addr_t     mod_base  [2];
  cpu_types_pkg::word_t     mod_data  [2][2];
  coherence_pkg::core_t     lru_model;
  // latency the RAM runs with
  cpu_types_pkg::latency_t  cur_latency;
  string                    test_name;

  memory_subsystem #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) dut0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .cfg_wen     (cfg_wen),
    .cfg_latency (cfg_latency),
    .iREN        (iREN),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .ccwrite     (ccwrite),
    .cctrans     (cctrans),
    .iaddr       (iaddr),
    .daddr       (daddr),
    .dstore      (dstore),
    .iwait       (iwait),
    .dwait       (dwait),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .iload       (iload),
    .dload       (dload),
    .ccsnoopaddr (ccsnoopaddr)
  );

  bind coherence_control memory_subsystem_checker chk0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .iREN        (iREN),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .ccwrite     (ccwrite),
    .daddr       (daddr),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .ramREN      (ramREN),
    .ramWEN      (ramWEN)
  );

  initial
  begin
    CLK = 1'b0;
  end

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task abort_run();
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  // stop at the first bound assertion failure
  always @(negedge CLK)
  begin
    if (dut0.ctrl0.chk0.fail_count != 0)
    begin
      $display("a bound assertion failed");
      abort_run();
    end
  end

  task compare_word(input string what, input cpu_types_pkg::word_t exp,
                    input cpu_types_pkg::word_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task compare_addr(input string what, input cpu_types_pkg::addr_t exp,
                    input cpu_types_pkg::addr_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // word part of a byte address
  function automatic int mem_index(input cpu_types_pkg::addr_t a);
    return int'(a[MEM_ADDR_BITS+1:2]);
  endfunction

  // four blocks only, so cores keep colliding
  function automatic cpu_types_pkg::addr_t random_base();
    return ADDR_BASE + 32'(8 * $urandom_range(0, 3));
  endfunction

  // fetch already raised, wait for its grant
  task wait_fetch(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t a);
    logic done_now;
    done_now = 1'b0;
    while (!done_now)
    begin
      @(negedge CLK);
      done_now = !iwait[c];
      if (done_now)
      begin
        compare_word("iload", model_mem[mem_index(a)], iload[c]);
      end
    end
    @(posedge CLK);
    iREN[c]   <= 1'b0;
    lru_model = ~c;
  endtask

  // one idle cycle, one RAM start cycle, then latency cycles before the grant
  task do_fetch(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t a);
    @(posedge CLK);
    iREN[c]  <= 1'b1;
    iaddr[c] <= a;
    repeat (int'(cur_latency) + 2)
    begin
      @(negedge CLK);
      compare_flag("iwait before access", 1'b1, iwait[c]);
    end
    @(negedge CLK);
    compare_flag("iwait at access", 1'b0, iwait[c]);
    compare_word("iload", model_mem[mem_index(a)], iload[c]);
    @(posedge CLK);
    iREN[c]   <= 1'b0;
    lru_model = ~c;
  endtask

  // both cores fetch at once, lru core goes first
  task do_dual_fetch(input cpu_types_pkg::addr_t a0, input cpu_types_pkg::addr_t a1);
    coherence_pkg::core_t first;
    coherence_pkg::core_t k;
    cpu_types_pkg::addr_t a [2];
    int                   served;
    a[0]   = a0;
    a[1]   = a1;
    first  = lru_model;
    served = 0;
    @(posedge CLK);
    iREN[0]  <= 1'b1;
    iREN[1]  <= 1'b1;
    iaddr[0] <= a0;
    iaddr[1] <= a1;
    while (served < 2)
    begin
      k = (served == 0) ? first : ~first;
      @(negedge CLK);
      compare_flag("fetch order", 1'b1, iwait[~k]);
      if (!iwait[k])
      begin
        compare_word("iload", model_mem[mem_index(a[k])], iload[k]);
        served++;
        @(posedge CLK);
        iREN[k]   <= 1'b0;
        lru_model = ~k;
      end
    end
  endtask

  // two-word write-back, optionally racing a fetch of the same base
  task do_store(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t base,
                input cpu_types_pkg::word_t d0, input cpu_types_pkg::word_t d1,
                input logic with_fetch, input coherence_pkg::core_t fc);
    int   n;
    logic done_now;
    n = 0;
    @(posedge CLK);
    dWEN[c]   <= 1'b1;
    daddr[c]  <= base;
    dstore[c] <= d0;
    if (with_fetch)
    begin
      iREN[fc]  <= 1'b1;
      iaddr[fc] <= base;
    end
    while (n < 2)
    begin
      @(negedge CLK);
      done_now = !dwait[c];
      if (with_fetch)
      begin
        compare_flag("iwait behind write-back", 1'b1, iwait[fc]);
      end
      @(posedge CLK);
      if (done_now)
      begin
        n++;
        if (n == 1)
        begin
          daddr[c]  <= base + 4;
          dstore[c] <= d1;
        end
        else
        begin
          dWEN[c] <= 1'b0;
        end
      end
    end
    model_mem[mem_index(base)]     = d0;
    model_mem[mem_index(base + 4)] = d1;
    lru_model                      = ~c;
    if (with_fetch)
    begin
      wait_fetch(fc, base);
    end
  endtask

  // modified block elsewhere goes back to memory first
  task evict(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t base);
    if (mod_valid[c] && (mod_base[c] != base))
    begin
      do_store(c, mod_base[c], mod_data[c][0], mod_data[c][1], 1'b0, c);
      mod_valid[c] = 1'b0;
    end
  endtask

  // load with snoop, forwarded if the other cache holds it modified
  task do_load(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t base,
               input logic w);
    coherence_pkg::core_t o;
    logic                 hit;
    logic                 snooping;
    logic                 done_now;
    int                   n;
    cpu_types_pkg::word_t exp [2];
    o        = ~c;
    hit      = mod_valid[o] && (mod_base[o] == base);
    n        = 0;
    snooping = 1'b0;
    for (int i = 0; i < 2; i++)
    begin
      exp[i] = hit ? mod_data[o][i] : model_mem[mem_index(base + 4 * i)];
    end
    @(posedge CLK);
    dREN[c]    <= 1'b1;
    daddr[c]   <= base;
    ccwrite[c] <= w;
    if (hit)
    begin
      dstore[o] <= exp[0];
    end
    while (n < 2)
    begin
      @(negedge CLK);
      if (ccwait[o])
      begin
        snooping = 1'b1;
      end
      // snooped cache held on the requester's address to the end
      if (snooping)
      begin
        compare_flag("snooped ccwait", 1'b1, ccwait[o]);
        compare_addr("ccsnoopaddr", base + 4 * n, ccsnoopaddr[o]);
      end
      done_now = !dwait[c];
      if (done_now)
      begin
        compare_flag("snoop before data", 1'b1, snooping);
        compare_word("dload", exp[n], dload[c]);
        compare_flag("snooped dwait", !hit, dwait[o]);
        compare_flag("snooped ccinv", hit && w, ccinv[o]);
      end
      @(posedge CLK);
      // answer the snoop once it has been seen
      cctrans[o] <= snooping && hit;
      if (done_now)
      begin
        n++;
        if (n == 1)
        begin
          daddr[c] <= base + 4;
          if (hit)
          begin
            dstore[o] <= exp[1];
          end
        end
        else
        begin
          dREN[c]    <= 1'b0;
          ccwrite[c] <= 1'b0;
          cctrans[o] <= 1'b0;
        end
      end
    end
    if (hit)
    begin
      model_mem[mem_index(base)]     = exp[0];
      model_mem[mem_index(base + 4)] = exp[1];
      mod_valid[o]                   = 1'b0;
    end
    if (w)
    begin
      // requester writes new data into the block
      mod_valid[c]   = 1'b1;
      mod_base[c]    = base;
      mod_data[c][0] = $urandom;
      mod_data[c][1] = $urandom;
    end
    else if (mod_valid[c] && (mod_base[c] == base))
    begin
      mod_valid[c] = 1'b0;
    end
    lru_model = ~c;
  endtask

  // write hit on shared, single invalidate cycle
  task do_upgrade(input coherence_pkg::core_t c, input cpu_types_pkg::addr_t base);
    coherence_pkg::core_t o;
    logic                 seen;
    o    = ~c;
    seen = 1'b0;
    @(posedge CLK);
    ccwrite[c] <= 1'b1;
    daddr[c]   <= base;
    while (!seen)
    begin
      @(negedge CLK);
      if (ccinv[o])
      begin
        compare_addr("upgrade ccsnoopaddr", base, ccsnoopaddr[o]);
        compare_flag("writer ccinv", 1'b0, ccinv[c]);
        seen = 1'b1;
      end
    end
    @(posedge CLK);
    ccwrite[c]     <= 1'b0;
    mod_valid[c]   = 1'b1;
    mod_base[c]    = base;
    mod_data[c][0] = $urandom;
    mod_data[c][1] = $urandom;
    lru_model      = ~c;
  endtask

  task set_latency(input cpu_types_pkg::latency_t l);
    @(posedge CLK);
    cfg_wen     <= 1'b1;
    cfg_latency <= l;
    @(posedge CLK);
    cfg_wen <= 1'b0;
    // taken at this edge, the RAM port is idle
    cur_latency = l;
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("run hung, a wait was never released");
    abort_run();
  end

  initial
  begin : stimulus
    int                   seed_value;
    int                   op;
    coherence_pkg::core_t c;
    cpu_types_pkg::addr_t base;
    logic                 w;
    nRST        = 1'b0;
    cfg_wen     = 1'b0;
    cfg_latency = '0;
    for (int k = 0; k < 2; k++)
    begin
      iREN[k]      = 1'b0;
      dREN[k]      = 1'b0;
      dWEN[k]      = 1'b0;
      ccwrite[k]   = 1'b0;
      cctrans[k]   = 1'b0;
      iaddr[k]     = ADDR_BASE;
      daddr[k]     = ADDR_BASE;
      dstore[k]    = '0;
      mod_valid[k] = 1'b0;
      mod_base[k]  = ADDR_BASE;
    end
    // RAM clears at reset
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      model_mem[i] = '0;
    end
    lru_model   = 1'b0;
    cur_latency = '0;
    test_name   = "reset";
    seed_value  = $urandom(32'hdead4f07);
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;

    for (int t = 0; t < NUM_TRANS; t++)
    begin
      op   = $urandom_range(0, 7);
      c    = 1'($urandom_range(0, 1));
      base = random_base();
      w    = 1'($urandom_range(0, 1));
      case (op)
        0:
        begin
          test_name = $sformatf("fetch_%0d", t);
          do_fetch(c, base + 32'(4 * $urandom_range(0, 1)));
        end
        1:
        begin
          test_name = $sformatf("dual_fetch_%0d", t);
          do_dual_fetch(random_base(), random_base() + 4);
        end
        2, 3:
        begin
          test_name = $sformatf("write_back_%0d", t);
          if (mod_valid[c])
          begin
            base = mod_base[c];
            do_store(c, base, mod_data[c][0], mod_data[c][1], op == 3, ~c);
            mod_valid[c] = 1'b0;
          end
          else
          begin
            do_store(c, base, $urandom, $urandom, op == 3, 1'($urandom_range(0, 1)));
          end
          // second word read back on its own
          do_fetch(1'($urandom_range(0, 1)), base + 4);
        end
        4, 5:
        begin
          // aim at the other cache's modified block half the time
          if (mod_valid[~c] && $urandom_range(0, 1))
          begin
            base = mod_base[~c];
          end
          test_name = $sformatf("load_%0d", t);
          if (w)
          begin
            evict(c, base);
          end
          do_load(c, base, w);
        end
        6:
        begin
          test_name = $sformatf("upgrade_%0d", t);
          evict(c, base);
          // modified elsewhere is a read for ownership, not an upgrade
          if (mod_valid[~c] && (mod_base[~c] == base))
          begin
            do_load(c, base, 1'b1);
          end
          else
          begin
            do_upgrade(c, base);
          end
        end
        default:
        begin
          test_name = $sformatf("latency_%0d", t);
          set_latency(4'($urandom_range(0, 15)));
        end
      endcase
    end

    @(posedge CLK);
    if (dut0.ctrl0.chk0.fail_count == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("bound assertions failed %0d times", dut0.ctrl0.chk0.fail_count);
      abort_run();
    end
  end

endmodule

//--- memory_subsystem.f
cpu_types_pkg.sv
coherence_pkg.sv
ram_latency_cfg.sv
ram_model.sv
coherence_control.sv
memory_subsystem.sv
memory_subsystem_checker.sv
tb_memory_subsystem.sv

//--- Bender.yml
package:
  name: memory_subsystem

sources:
  - files:
      - cpu_types_pkg.sv
      - coherence_pkg.sv
      - ram_latency_cfg.sv
      - ram_model.sv
      - coherence_control.sv
      - memory_subsystem.sv
  - target: test
    files:
      - memory_subsystem_checker.sv
      - tb_memory_subsystem.sv
